// ==== filelist.f ====
hdl/icu_pkg.sv
hdl/icu_way_ram.sv
hdl/icu_way_fetch.sv
hdl/icu_way_align.sv
hdl/icu_way_judge.sv
hdl/icu_way_top.sv
tb/tb_icu_way_checker.sv
tb/tb_icu_way.sv

// ==== hdl/icu_pkg.sv ====
/*
 * Shared types for one instruction-cache way: request, page descriptor,
 * memory word and the records passed between the three lookup stages.
 * Modules refer to these by scoped name.
 */
package icu_pkg;

    // ==========================================================================
    // address layout
    // ==========================================================================
    // word offset inside a line
    localparam int ICU_LINE_OFS_LSB = 3;
    localparam int ICU_LINE_OFS_W   = 3;

    // lowest page-index bit of the virtual address
    localparam int ICU_PAGE_LSB     = 6;

    // descriptor vpage covers address bits 31 down to this one
    localparam int ICU_VPAGE_LSB    = 11;

    // ==========================================================================
    // lookup request and page descriptor
    // ==========================================================================
    typedef struct packed {
        logic        tid;
        logic [1:0]  pid;
        logic [3:0]  asid;
        logic [31:0] vaddr;
    } icu_req_t;

    // 36 bits, msb first
    typedef struct packed {
        logic [3:0]  asid;
        logic [20:0] vpage;
        logic        valid;
        logic        av;       // translation available
        logic        locked;
        logic        tag;
        logic        wrt;
        logic [1:0]  pid;      // lowest privilege allowed
        logic        exe;
        logic        rd;
        logic        wr;
        logic        dbg;
    } icu_desc_t;

    // 72-bit line memory word
    typedef struct packed {
        logic [4:0]  spare;
        logic        ext;      // word holds a 64-bit instruction pair
        logic [1:0]  ext3;
        logic [63:0] data;
    } icu_line_t;

    // ==========================================================================
    // stage records
    // ==========================================================================
    // fetch to align
    typedef struct packed {
        logic     stb;
        icu_req_t req;
        logic     col;
    } icu_fetch_t;

    // align to judge
    typedef struct packed {
        logic        stb;
        icu_req_t    req;
        logic        col;
        icu_desc_t   desc;
        logic [63:0] data;
        logic        skip;
        logic        iext;
    } icu_align_t;

endpackage

// ==== hdl/icu_way_align.sv ====
/*
 * Stage a2 of the way lookup. Registers the fetch results and picks the
 * instruction word or pair out of the memory word by address bit 2 and
 * the word's ext flag. Payload is only captured on a valid lookup.
 */
module icu_way_align
(
    input  logic                 clk,
    input  logic                 rst,

    input  icu_pkg::icu_fetch_t  i_fetch,
    input  icu_pkg::icu_desc_t   i_desc,
    input  icu_pkg::icu_line_t   i_line,

    output icu_pkg::icu_align_t  o_align
);

    logic        a2;
    logic        ext;
    logic [63:0] sel_data;

    assign a2  = i_fetch.req.vaddr[2];
    assign ext = i_line.ext;

    // word select
    always_comb
    begin
        case ({a2, ext})
            2'b00:   sel_data = {32'd0, i_line.data[63:32]};
            2'b01:   sel_data = 64'd0;
            2'b10:   sel_data = {32'd0, i_line.data[31:0]};
            default: sel_data = i_line.data;
        endcase
    end

    // ==========================================================================
    // stage register
    // ==========================================================================
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            o_align <= '0;
        end
        else
        begin
            o_align.stb <= i_fetch.stb;
            o_align.col <= i_fetch.col;
            if (i_fetch.stb)
            begin
                o_align.req  <= i_fetch.req;
                o_align.desc <= i_desc;
                o_align.data <= sel_data;
                // second half of a pair fetched at the low word
                o_align.skip <= ext && !a2;
                o_align.iext <= ext && a2;
            end
        end
    end

endmodule

// ==== hdl/icu_way_fetch.sv ====
/*
 * Stage b1 of the way lookup. Registers the request, reads the page
 * descriptor and the line word, and flags a descriptor write that hits
 * the same thread and page in the lookup cycle.
 */
module icu_way_fetch
#(
    parameter int PAGE_ADDR_WIDTH = 5
)
(
    input  logic                                  clk,
    input  logic                                  rst,

    input  logic                                  i_stb,
    input  icu_pkg::icu_req_t                     i_req,

    input  logic                                  i_mm_wr_stb,
    input  logic                                  i_mm_wr_tid,
    input  logic [PAGE_ADDR_WIDTH-1:0]            i_mm_wr_page,
    input  logic [icu_pkg::ICU_LINE_OFS_W-1:0]    i_mm_wr_offset,
    input  icu_pkg::icu_line_t                    i_mm_wr_data,

    input  logic                                  i_pt_wr_stb,
    input  logic                                  i_pt_wr_tid,
    input  logic [PAGE_ADDR_WIDTH-1:0]            i_pt_wr_page,
    input  icu_pkg::icu_desc_t                    i_pt_wr_desc,

    output icu_pkg::icu_fetch_t                   o_fetch,
    output icu_pkg::icu_desc_t                    o_desc,
    output icu_pkg::icu_line_t                    o_line
);

    // table index {tid, page}, line index {tid, page, offset}
    localparam int DESC_ADDR_W = PAGE_ADDR_WIDTH + 1;
    localparam int LINE_ADDR_W = PAGE_ADDR_WIDTH + 1 + icu_pkg::ICU_LINE_OFS_W;

    logic [PAGE_ADDR_WIDTH-1:0]         rd_page;
    logic [icu_pkg::ICU_LINE_OFS_W-1:0] rd_offset;
    logic                               wr_col;

    assign rd_page   = i_req.vaddr[icu_pkg::ICU_PAGE_LSB +: PAGE_ADDR_WIDTH];
    assign rd_offset = i_req.vaddr[icu_pkg::ICU_LINE_OFS_LSB +: icu_pkg::ICU_LINE_OFS_W];

    // descriptor being rewritten while we read it
    assign wr_col = i_pt_wr_stb && (i_pt_wr_tid == i_req.tid) && (i_pt_wr_page == rd_page);

    // ==========================================================================
    // page descriptor table
    // ==========================================================================
    icu_way_ram #(
        .T          (icu_pkg::icu_desc_t),
        .ADDR_WIDTH (DESC_ADDR_W)
    ) desc_ram_i (
        .clk       (clk),
        .i_wr_stb  (i_pt_wr_stb),
        .i_wr_addr ({i_pt_wr_tid, i_pt_wr_page}),
        .i_wr_data (i_pt_wr_desc),
        .i_rd_addr ({i_req.tid, rd_page}),
        .o_rd_data (o_desc)
    );

    // ==========================================================================
    // line memory
    // ==========================================================================
    icu_way_ram #(
        .T          (icu_pkg::icu_line_t),
        .ADDR_WIDTH (LINE_ADDR_W)
    ) line_ram_i (
        .clk       (clk),
        .i_wr_stb  (i_mm_wr_stb),
        .i_wr_addr ({i_mm_wr_tid, i_mm_wr_page, i_mm_wr_offset}),
        .i_wr_data (i_mm_wr_data),
        .i_rd_addr ({i_req.tid, rd_page, rd_offset}),
        .o_rd_data (o_line)
    );

    // request register, same edge as both memory reads
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            o_fetch <= '0;
        end
        else
        begin
            o_fetch.stb <= i_stb;
            o_fetch.req <= i_req;
            o_fetch.col <= wr_col;
        end
    end

endmodule

// ==== hdl/icu_way_judge.sv ====
/*
 * Stage b3 of the way lookup. Compares the descriptor with the staged
 * request, derives hit, miss, locked and empty, raises TLB and page
 * exceptions and registers every way output.
 */
module icu_way_judge
#(
    parameter int PAGE_ADDR_WIDTH = 5
)
(
    input  logic                 clk,
    input  logic                 rst,

    input  icu_pkg::icu_align_t  i_align,

    output logic                 o_stb,
    output logic                 o_tid,
    output logic                 o_hit,
    output logic                 o_miss,
    output logic                 o_locked,
    output logic                 o_empty,
    output logic                 o_tag,

    output logic                 o_exc,
    output logic [3:0]           o_exc_ida,
    output logic [3:0]           o_exc_idp,
    output logic [3:0]           o_exc_idt,

    output logic [63:0]          o_data,

    output logic                 o_inst_skip,
    output logic                 o_inst_ext
);

    // address bits above the page index take part in the tag compare
    localparam int CMP_LSB = icu_pkg::ICU_PAGE_LSB + PAGE_ADDR_WIDTH;

    icu_pkg::icu_req_t  req;
    icu_pkg::icu_desc_t desc;
    logic [31:0]        way_vaddr;
    logic               asid_val;
    logic               addr_val;
    logic               way_ok;
    logic               way_hit;
    logic               way_locked;
    logic               way_empty;
    logic               exc_aa;
    logic               exc_rd;
    logic               exc_exe;
    logic               exc_pid;
    logic               exc_page;
    logic               exc_tlb;
    logic               hit_gated;

    assign req  = i_align.req;
    assign desc = i_align.desc;

    // ==========================================================================
    // compare
    // ==========================================================================
    assign way_vaddr = {desc.vpage, {icu_pkg::ICU_VPAGE_LSB{1'b0}}};
    assign asid_val  = desc.asid == req.asid;
    assign addr_val  = way_vaddr[31:CMP_LSB] == req.vaddr[31:CMP_LSB];
    assign way_ok    = desc.valid && desc.av;

    assign way_hit    = asid_val && addr_val && way_ok;
    assign way_locked = i_align.col || desc.locked;
    assign way_empty  = !desc.locked && !desc.valid;

    // access faults, only on a usable translation
    assign exc_aa  = (|req.vaddr[1:0]) && way_ok;
    assign exc_rd  = !desc.rd && way_ok;
    assign exc_exe = !desc.exe && way_ok;
    assign exc_pid = (desc.pid < req.pid) && way_ok;

    assign exc_page = exc_aa || exc_rd || exc_exe || exc_pid;
    assign exc_tlb  = addr_val && desc.valid && !desc.av;

    assign hit_gated = !way_locked && way_hit && i_align.stb;

    // ==========================================================================
    // output register
    // ==========================================================================
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            o_stb       <= 1'b0;
            o_tid       <= 1'b0;
            o_hit       <= 1'b0;
            o_miss      <= 1'b0;
            o_locked    <= 1'b0;
            o_empty     <= 1'b0;
            o_tag       <= 1'b0;
            o_exc       <= 1'b0;
            o_exc_ida   <= 4'd0;
            o_exc_idp   <= 4'd0;
            o_exc_idt   <= 4'd0;
            o_data      <= 64'd0;
            o_inst_skip <= 1'b0;
            o_inst_ext  <= 1'b0;
        end
        else
        begin
            o_stb    <= i_align.stb;
            o_tid    <= req.tid;
            o_hit    <= hit_gated;
            o_miss   <= !way_locked && !way_hit && i_align.stb;
            o_locked <= way_locked && i_align.stb;
            o_empty  <= !way_locked && way_empty && i_align.stb;
            o_tag    <= desc.tag && i_align.stb;

            o_exc     <= (exc_tlb || exc_page) && i_align.stb;
            // codes follow the descriptor whether or not a lookup is present
            o_exc_ida <= {exc_exe, exc_rd, 2'b00};
            o_exc_idp <= {2'b00, exc_aa, exc_pid};
            o_exc_idt <= {3'b000, exc_tlb};

            o_data      <= i_align.data;
            o_inst_skip <= i_align.skip && hit_gated;
            o_inst_ext  <= i_align.iext && hit_gated;
        end
    end

endmodule

// ==== hdl/icu_way_ram.sv ====
/*
 * Single write port, single registered read port memory.
 * The payload type is a parameter so one body serves the descriptor
 * table and the line memory. A same-cycle read sees the old word.
 */
module icu_way_ram
#(
    parameter type T          = logic [7:0],
    parameter int  ADDR_WIDTH = 4
)
(
    input  logic                  clk,

    input  logic                  i_wr_stb,
    input  logic [ADDR_WIDTH-1:0] i_wr_addr,
    input  T                      i_wr_data,

    input  logic [ADDR_WIDTH-1:0] i_rd_addr,
    output T                      o_rd_data
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    T mem [0:DEPTH-1];

    // write port
    always_ff @(posedge clk)
    begin
        if (i_wr_stb)
        begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // read port, registered
    // nonblocking write above keeps read-before-write order
    always_ff @(posedge clk)
    begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

// ==== hdl/icu_way_top.sv ====
/*
 * One instruction-cache way for a two-thread core. Chains fetch, align
 * and judge; a lookup issued at edge k appears after edge k+3.
 * PAGE_ADDR_WIDTH sets the number of page-index bits, 1 to 5.
 */
module icu_way_top
#(
    parameter int PAGE_ADDR_WIDTH = 5
)
(
    input  logic                                  clk,
    input  logic                                  rst,

    // lookup
    input  logic                                  i_stb,
    input  icu_pkg::icu_req_t                     i_req,

    // line write
    input  logic                                  i_mm_wr_stb,
    input  logic                                  i_mm_wr_tid,
    input  logic [PAGE_ADDR_WIDTH-1:0]            i_mm_wr_page,
    input  logic [icu_pkg::ICU_LINE_OFS_W-1:0]    i_mm_wr_offset,
    input  icu_pkg::icu_line_t                    i_mm_wr_data,

    // descriptor write
    input  logic                                  i_pt_wr_stb,
    input  logic                                  i_pt_wr_tid,
    input  logic [PAGE_ADDR_WIDTH-1:0]            i_pt_wr_page,
    input  icu_pkg::icu_desc_t                    i_pt_wr_desc,

    output logic                                  o_stb,
    output logic                                  o_tid,
    output logic                                  o_hit,
    output logic                                  o_miss,
    output logic                                  o_locked,
    output logic                                  o_empty,
    output logic                                  o_tag,
    output logic                                  o_exc,
    output logic [3:0]                            o_exc_ida,
    output logic [3:0]                            o_exc_idp,
    output logic [3:0]                            o_exc_idt,
    output logic [63:0]                           o_data,
    output logic                                  o_inst_skip,
    output logic                                  o_inst_ext
);

    icu_pkg::icu_fetch_t b1_fetch;
    icu_pkg::icu_desc_t  b1_desc;
    icu_pkg::icu_line_t  b1_line;
    icu_pkg::icu_align_t a2_align;

    // ==========================================================================
    // b1, memory read
    // ==========================================================================
    icu_way_fetch #(
        .PAGE_ADDR_WIDTH (PAGE_ADDR_WIDTH)
    ) fetch_i (
        .clk            (clk),
        .rst            (rst),
        .i_stb          (i_stb),
        .i_req          (i_req),
        .i_mm_wr_stb    (i_mm_wr_stb),
        .i_mm_wr_tid    (i_mm_wr_tid),
        .i_mm_wr_page   (i_mm_wr_page),
        .i_mm_wr_offset (i_mm_wr_offset),
        .i_mm_wr_data   (i_mm_wr_data),
        .i_pt_wr_stb    (i_pt_wr_stb),
        .i_pt_wr_tid    (i_pt_wr_tid),
        .i_pt_wr_page   (i_pt_wr_page),
        .i_pt_wr_desc   (i_pt_wr_desc),
        .o_fetch        (b1_fetch),
        .o_desc         (b1_desc),
        .o_line         (b1_line)
    );

    // a2, word select
    icu_way_align align_i (
        .clk     (clk),
        .rst     (rst),
        .i_fetch (b1_fetch),
        .i_desc  (b1_desc),
        .i_line  (b1_line),
        .o_align (a2_align)
    );

    // ==========================================================================
    // b3, compare and outputs
    // ==========================================================================
    icu_way_judge #(
        .PAGE_ADDR_WIDTH (PAGE_ADDR_WIDTH)
    ) judge_i (
        .clk         (clk),
        .rst         (rst),
        .i_align     (a2_align),
        .o_stb       (o_stb),
        .o_tid       (o_tid),
        .o_hit       (o_hit),
        .o_miss      (o_miss),
        .o_locked    (o_locked),
        .o_empty     (o_empty),
        .o_tag       (o_tag),
        .o_exc       (o_exc),
        .o_exc_ida   (o_exc_ida),
        .o_exc_idp   (o_exc_idp),
        .o_exc_idt   (o_exc_idt),
        .o_data      (o_data),
        .o_inst_skip (o_inst_skip),
        .o_inst_ext  (o_inst_ext)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the way testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_icu_way -f filelist.f -o sim_icu_way

./obj_dir/sim_icu_way | tee sim.log

if grep -q "Testbench passed" sim.log; then
    exit 0
fi
exit 1

// ==== tb/tb_icu_way.sv ====
/*
 * Testbench top for one instruction-cache way. Builds a table of
 * descriptor writes, line writes and lookups with expected results,
 * drives it row by row and leaves the comparing to the checker.
 */
module tb_icu_way;

    // expected way outputs of one lookup in 85 bits
    typedef struct packed {
        logic        tid;
        logic        hit;
        logic        miss;
        logic        locked;
        logic        empty;
        logic        tag;
        logic        exc;
        logic [3:0]  ida;
        logic [3:0]  idp;
        logic [3:0]  idt;
        logic [63:0] data;
        logic        skip;
        logic        ext;
    } exp_t;

    // one stimulus row whose writes and lookup may share a cycle
    typedef struct packed {
        logic               do_pt;
        logic               do_mm;
        logic               do_lk;
        logic               tid;
        logic [4:0]         page;
        logic [2:0]         ofs;
        icu_pkg::icu_desc_t desc;
        icu_pkg::icu_line_t line;
        icu_pkg::icu_req_t  req;
    } row_t;

    logic                clk;
    logic                rst;
    logic                i_stb;
    icu_pkg::icu_req_t   i_req;
    logic                i_mm_wr_stb;
    logic                i_mm_wr_tid;
    logic [4:0]          i_mm_wr_page;
    logic [2:0]          i_mm_wr_offset;
    icu_pkg::icu_line_t  i_mm_wr_data;
    logic                i_pt_wr_stb;
    logic                i_pt_wr_tid;
    logic [4:0]          i_pt_wr_page;
    icu_pkg::icu_desc_t  i_pt_wr_desc;

    logic                o_stb;
    logic                o_tid;
    logic                o_hit;
    logic                o_miss;
    logic                o_locked;
    logic                o_empty;
    logic                o_tag;
    logic                o_exc;
    logic [3:0]          o_exc_ida;
    logic [3:0]          o_exc_idp;
    logic [3:0]          o_exc_idt;
    logic [63:0]         o_data;
    logic                o_inst_skip;
    logic                o_inst_ext;

    logic                exp_push;
    exp_t                exp_row;
    int                  errors;
    int                  pending;

    row_t                rows[$];
    exp_t                exps[$];
    int                  limit;
    int                  run_cyc;

    icu_pkg::icu_desc_t  d_good0;
    icu_pkg::icu_desc_t  d_good1;
    icu_pkg::icu_line_t  lw0;
    icu_pkg::icu_line_t  lw1;
    icu_pkg::icu_line_t  lw2;
    icu_pkg::icu_line_t  lw3;

    icu_way_top #(
        .PAGE_ADDR_WIDTH (5)
    ) icu_way_top_i (
        .clk            (clk),
        .rst            (rst),
        .i_stb          (i_stb),
        .i_req          (i_req),
        .i_mm_wr_stb    (i_mm_wr_stb),
        .i_mm_wr_tid    (i_mm_wr_tid),
        .i_mm_wr_page   (i_mm_wr_page),
        .i_mm_wr_offset (i_mm_wr_offset),
        .i_mm_wr_data   (i_mm_wr_data),
        .i_pt_wr_stb    (i_pt_wr_stb),
        .i_pt_wr_tid    (i_pt_wr_tid),
        .i_pt_wr_page   (i_pt_wr_page),
        .i_pt_wr_desc   (i_pt_wr_desc),
        .o_stb          (o_stb),
        .o_tid          (o_tid),
        .o_hit          (o_hit),
        .o_miss         (o_miss),
        .o_locked       (o_locked),
        .o_empty        (o_empty),
        .o_tag          (o_tag),
        .o_exc          (o_exc),
        .o_exc_ida      (o_exc_ida),
        .o_exc_idp      (o_exc_idp),
        .o_exc_idt      (o_exc_idt),
        .o_data         (o_data),
        .o_inst_skip    (o_inst_skip),
        .o_inst_ext     (o_inst_ext)
    );

    tb_icu_way_checker checker_i (
        .clk         (clk),
        .i_push      (exp_push),
        .i_exp       (exp_row),
        .i_stb       (o_stb),
        .i_tid       (o_tid),
        .i_hit       (o_hit),
        .i_miss      (o_miss),
        .i_locked    (o_locked),
        .i_empty     (o_empty),
        .i_tag       (o_tag),
        .i_exc       (o_exc),
        .i_exc_ida   (o_exc_ida),
        .i_exc_idp   (o_exc_idp),
        .i_exc_idt   (o_exc_idt),
        .i_data      (o_data),
        .i_inst_skip (o_inst_skip),
        .i_inst_ext  (o_inst_ext),
        .o_errors    (errors),
        .o_pending   (pending)
    );

    always #50 clk = ~clk;

    // ========================================================================
    // table helpers
    // ========================================================================
    function automatic icu_pkg::icu_desc_t mk_desc(logic [3:0] asid, logic [20:0] vpage,
        logic valid, logic av, logic locked, logic tag, logic [1:0] pid, logic exe, logic rd);
        icu_pkg::icu_desc_t d;
        logic [31:0]        rnd;
        rnd      = $urandom;
        d.asid   = asid;
        d.vpage  = vpage;
        d.valid  = valid;
        d.av     = av;
        d.locked = locked;
        d.tag    = tag;
        d.wrt    = rnd[0];
        d.pid    = pid;
        d.exe    = exe;
        d.rd     = rd;
        d.wr     = rnd[1];
        d.dbg    = rnd[2];
        return d;
    endfunction

    function automatic icu_pkg::icu_line_t mk_line(logic ext);
        icu_pkg::icu_line_t l;
        logic [31:0]        r0;
        logic [31:0]        r1;
        r0      = $urandom;
        r1      = $urandom;
        l.spare = r0[4:0];
        l.ext   = ext;
        l.ext3  = r1[1:0];
        l.data  = {r0, r1};
        return l;
    endfunction

    function automatic logic [31:0] mk_va(logic [20:0] vp, logic [4:0] pg, logic [2:0] ofs,
        logic a2, logic [1:0] lo);
        return {vp, pg, ofs, a2, lo};
    endfunction

    task automatic add_pt(logic tid, logic [4:0] page, icu_pkg::icu_desc_t d);
        row_t r;
        r       = '0;
        r.do_pt = 1'b1;
        r.tid   = tid;
        r.page  = page;
        r.desc  = d;
        rows.push_back(r);
        exps.push_back('0);
    endtask

    task automatic add_mm(logic tid, logic [4:0] page, logic [2:0] ofs, icu_pkg::icu_line_t l);
        row_t r;
        r       = '0;
        r.do_mm = 1'b1;
        r.tid   = tid;
        r.page  = page;
        r.ofs   = ofs;
        r.line  = l;
        rows.push_back(r);
        exps.push_back('0);
    endtask

    // lookup with an optional descriptor write in the same cycle
    task automatic add_lk(logic tid, logic [3:0] asid, logic [31:0] va, logic pt_also,
        logic pt_tid, exp_t e);
        row_t r;
        r          = '0;
        r.do_lk    = 1'b1;
        r.req.tid  = tid;
        r.req.pid  = 2'd2;
        r.req.asid = asid;
        r.req.vaddr = va;
        r.do_pt    = pt_also;
        r.tid      = pt_tid;
        r.page     = 5'd3;
        r.desc     = d_good0;
        rows.push_back(r);
        exps.push_back(e);
    endtask

    function automatic exp_t mk_exp(logic tid, logic [4:0] flags, logic exc, logic [3:0] ida,
        logic [3:0] idp, logic [3:0] idt, logic [63:0] data, logic skip, logic ext);
        exp_t e;
        // flags in order hit miss locked empty tag
        e.tid    = tid;
        e.hit    = flags[4];
        e.miss   = flags[3];
        e.locked = flags[2];
        e.empty  = flags[1];
        e.tag    = flags[0];
        e.exc    = exc;
        e.ida    = ida;
        e.idp    = idp;
        e.idt    = idt;
        e.data   = data;
        e.skip   = skip;
        e.ext    = ext;
        return e;
    endfunction

    task automatic build_table();
        logic [20:0] vp0;
        logic [20:0] vp1;
        vp0     = 21'h0ABCD;
        vp1     = 21'h12345;
        d_good0 = mk_desc(4'd5, vp0, 1'b1, 1'b1, 1'b0, 1'b0, 2'd3, 1'b1, 1'b1);
        d_good1 = mk_desc(4'd9, vp1, 1'b1, 1'b1, 1'b0, 1'b1, 2'd3, 1'b1, 1'b1);
        lw0 = mk_line(1'b0);
        lw1 = mk_line(1'b1);
        lw2 = mk_line(1'b0);
        lw3 = mk_line(1'b0);

        add_pt(1'b0, 5'd3, d_good0);
        add_pt(1'b1, 5'd3, d_good1);
        // tlb miss, faulting page, locked page, empty page
        add_pt(1'b0, 5'd4, mk_desc(4'd5, vp0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd3, 1'b1, 1'b1));
        add_pt(1'b0, 5'd5, mk_desc(4'd5, vp0, 1'b1, 1'b1, 1'b0, 1'b0, 2'd1, 1'b0, 1'b0));
        add_pt(1'b0, 5'd6, mk_desc(4'd5, vp0, 1'b0, 1'b1, 1'b1, 1'b0, 2'd3, 1'b1, 1'b1));
        add_pt(1'b0, 5'd7, mk_desc(4'd0, 21'd0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 1'b0));
        add_mm(1'b0, 5'd3, 3'd0, lw0);
        add_mm(1'b0, 5'd3, 3'd1, lw1);
        add_mm(1'b1, 5'd3, 3'd0, lw2);
        for (int p = 4; p < 8; p++)
        begin
            add_mm(1'b0, p[4:0], 3'd0, lw3);
        end

        // four word-select cases
        add_lk(1'b0, 4'd5, mk_va(vp0, 5'd3, 3'd0, 1'b0, 2'd0), 1'b0, 1'b0,
            mk_exp(1'b0, 5'b10000, 1'b0, 4'd0, 4'd0, 4'd0, {32'd0, lw0.data[63:32]}, 1'b0, 1'b0));
        add_lk(1'b0, 4'd5, mk_va(vp0, 5'd3, 3'd0, 1'b1, 2'd0), 1'b0, 1'b0,
            mk_exp(1'b0, 5'b10000, 1'b0, 4'd0, 4'd0, 4'd0, {32'd0, lw0.data[31:0]}, 1'b0, 1'b0));
        add_lk(1'b0, 4'd5, mk_va(vp0, 5'd3, 3'd1, 1'b0, 2'd0), 1'b0, 1'b0,
            mk_exp(1'b0, 5'b10000, 1'b0, 4'd0, 4'd0, 4'd0, 64'd0, 1'b1, 1'b0));
        add_lk(1'b0, 4'd5, mk_va(vp0, 5'd3, 3'd1, 1'b1, 2'd0), 1'b0, 1'b0,
            mk_exp(1'b0, 5'b10000, 1'b0, 4'd0, 4'd0, 4'd0, lw1.data, 1'b0, 1'b1));
        // asid mismatch, then vpage mismatch
        add_lk(1'b0, 4'd6, mk_va(vp0, 5'd3, 3'd0, 1'b0, 2'd0), 1'b0, 1'b0,
            mk_exp(1'b0, 5'b01000, 1'b0, 4'd0, 4'd0, 4'd0, {32'd0, lw0.data[63:32]}, 1'b0, 1'b0));
        add_lk(1'b0, 4'd5, mk_va(21'h0ABCE, 5'd3, 3'd0, 1'b0, 2'd0), 1'b0, 1'b0,
            mk_exp(1'b0, 5'b01000, 1'b0, 4'd0, 4'd0, 4'd0, {32'd0, lw0.data[63:32]}, 1'b0, 1'b0));
        // both threads back to back on page 3
        add_lk(1'b1, 4'd9, mk_va(vp1, 5'd3, 3'd0, 1'b0, 2'd0), 1'b0, 1'b0,
            mk_exp(1'b1, 5'b10001, 1'b0, 4'd0, 4'd0, 4'd0, {32'd0, lw2.data[63:32]}, 1'b0, 1'b0));
        add_lk(1'b0, 4'd5, mk_va(vp0, 5'd3, 3'd0, 1'b0, 2'd0), 1'b0, 1'b0,
            mk_exp(1'b0, 5'b10000, 1'b0, 4'd0, 4'd0, 4'd0, {32'd0, lw0.data[63:32]}, 1'b0, 1'b0));
        // tlb exception, access faults, locked, empty
        add_lk(1'b0, 4'd5, mk_va(vp0, 5'd4, 3'd0, 1'b0, 2'd0), 1'b0, 1'b0,
            mk_exp(1'b0, 5'b01000, 1'b1, 4'd0, 4'd0, 4'd1, {32'd0, lw3.data[63:32]}, 1'b0, 1'b0));
        add_lk(1'b0, 4'd5, mk_va(vp0, 5'd5, 3'd0, 1'b0, 2'd1), 1'b0, 1'b0,
            mk_exp(1'b0, 5'b10000, 1'b1, 4'hC, 4'h3, 4'd0, {32'd0, lw3.data[63:32]}, 1'b0, 1'b0));
        // a lone misaligned fault on a good page
        add_lk(1'b0, 4'd5, mk_va(vp0, 5'd3, 3'd0, 1'b0, 2'd2), 1'b0, 1'b0,
            mk_exp(1'b0, 5'b10000, 1'b1, 4'd0, 4'h2, 4'd0, {32'd0, lw0.data[63:32]}, 1'b0, 1'b0));
        add_lk(1'b0, 4'd5, mk_va(vp0, 5'd6, 3'd0, 1'b0, 2'd0), 1'b0, 1'b0,
            mk_exp(1'b0, 5'b00100, 1'b0, 4'd0, 4'd0, 4'd0, {32'd0, lw3.data[63:32]}, 1'b0, 1'b0));
        add_lk(1'b0, 4'd5, mk_va(vp0, 5'd7, 3'd0, 1'b0, 2'd0), 1'b0, 1'b0,
            mk_exp(1'b0, 5'b01010, 1'b0, 4'd0, 4'd0, 4'd0, {32'd0, lw3.data[63:32]}, 1'b0, 1'b0));
        // descriptor rewrite in the lookup cycle by the same thread and by the other
        add_lk(1'b0, 4'd5, mk_va(vp0, 5'd3, 3'd0, 1'b0, 2'd0), 1'b1, 1'b0,
            mk_exp(1'b0, 5'b00100, 1'b0, 4'd0, 4'd0, 4'd0, {32'd0, lw0.data[63:32]}, 1'b0, 1'b0));
        add_lk(1'b1, 4'd9, mk_va(vp1, 5'd3, 3'd0, 1'b0, 2'd0), 1'b1, 1'b0,
            mk_exp(1'b1, 5'b10001, 1'b0, 4'd0, 4'd0, 4'd0, {32'd0, lw2.data[63:32]}, 1'b0, 1'b0));
    endtask

    task automatic apply_row(row_t r, exp_t e);
        i_pt_wr_stb    = r.do_pt;
        i_pt_wr_tid    = r.tid;
        i_pt_wr_page   = r.page;
        i_pt_wr_desc   = r.desc;
        i_mm_wr_stb    = r.do_mm;
        i_mm_wr_tid    = r.tid;
        i_mm_wr_page   = r.page;
        i_mm_wr_offset = r.ofs;
        i_mm_wr_data   = r.line;
        i_stb          = r.do_lk;
        i_req          = r.req;
        exp_push       = r.do_lk;
        exp_row        = e;
    endtask

    // ========================================================================
    // timeout
    // ========================================================================
    always @(posedge clk)
    begin
        if (!rst)
        begin
            run_cyc = run_cyc + 1;
            if (run_cyc > limit)
            begin
                $display("Timeout after %0d cycles, lookups still outstanding", run_cyc);
                $display("Testbench failed");
                $finish;
            end
        end
    end

    initial
    begin
        void'($urandom(85));
        clk     = 1'b0;
        rst     = 1'b1;
        run_cyc = 0;
        limit   = 1000;
        apply_row('0, '0);
        build_table();
        limit = rows.size() * 4 + 20;

        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        for (int i = 0; i < rows.size(); i++)
        begin
            @(posedge clk);
            #1 apply_row(rows[i], exps[i]);
        end
        @(posedge clk);
        #1 apply_row('0, '0);

        // drain the pipeline
        while (pending != 0)
        begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);

        $display("rows: %0d, errors: %0d", rows.size(), errors);
        if (errors == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tb/tb_icu_way_checker.sv ====
/*
 * Watches the way outputs for the testbench. Expected results are
 * queued when a lookup is issued and compared three edges later.
 */
module tb_icu_way_checker
(
    input  logic        clk,
    input  logic        i_push,
    input  logic [84:0] i_exp,
    input  logic        i_stb,
    input  logic        i_tid,
    input  logic        i_hit,
    input  logic        i_miss,
    input  logic        i_locked,
    input  logic        i_empty,
    input  logic        i_tag,
    input  logic        i_exc,
    input  logic [3:0]  i_exc_ida,
    input  logic [3:0]  i_exc_idp,
    input  logic [3:0]  i_exc_idt,
    input  logic [63:0] i_data,
    input  logic        i_inst_skip,
    input  logic        i_inst_ext,
    output int          o_errors,
    output int          o_pending
);

    logic [84:0] q_exp[$];
    int          q_due[$];
    int          edges = 0;
    int          n_seen = 0;
    logic [84:0] got;

    // same field order as the expected record
    assign got = {i_tid, i_hit, i_miss, i_locked, i_empty, i_tag, i_exc,
                  i_exc_ida, i_exc_idp, i_exc_idt, i_data, i_inst_skip, i_inst_ext};

    initial
    begin
        o_errors  = 0;
        o_pending = 0;
    end

    always @(posedge clk)
    begin
        edges = edges + 1;
    end

    // sample half a cycle after the outputs move
    always @(negedge clk)
    begin
        if (i_push)
        begin
            q_exp.push_back(i_exp);
            q_due.push_back(edges + 3);
        end

        if (i_stb)
        begin
            if (q_exp.size() == 0)
            begin
                $display("Unexpected o_stb at time %0t with no lookup outstanding", $time);
                o_errors = o_errors + 1;
            end
            else
            begin
                if (edges != q_due[0])
                begin
                    $display("Lookup %0d came out at edge %0d instead of %0d, time %0t",
                        n_seen, edges, q_due[0], $time);
                    o_errors = o_errors + 1;
                end
                if (got !== q_exp[0])
                begin
                    $display("Mismatch at %0t: lookup %0d got %h expected %h", $time, n_seen,
                        got, q_exp[0]);
                    o_errors = o_errors + 1;
                end
                void'(q_exp.pop_front());
                void'(q_due.pop_front());
                n_seen = n_seen + 1;
            end
        end
        else
        begin
            if (q_due.size() != 0 && edges > q_due[0])
            begin
                $display("Lookup %0d never produced o_stb, time %0t", n_seen, $time);
                o_errors = o_errors + 1;
                void'(q_exp.pop_front());
                void'(q_due.pop_front());
                n_seen = n_seen + 1;
            end
            // nothing may leak out before the first result
            if (n_seen == 0 && got !== '0)
            begin
                $display("Outputs not zero before the first lookup result, time %0t", $time);
                o_errors = o_errors + 1;
            end
        end
        o_pending = q_exp.size();
    end

endmodule
